//--- Makefile
SIM = obj_dir/Vtb_mbox

SRCS = filelist.f mbox_config.svh mbox_pkg.sv mbox_regs.sv mbox_fsm.sv \
       mbox_ptr_ctrl.sv mbox_buffer.sv mbox_top.sv tb_mbox.sv

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --top-module tb_mbox -f filelist.f -o Vtb_mbox

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+.
mbox_pkg.sv
mbox_regs.sv
mbox_fsm.sv
mbox_ptr_ctrl.sv
mbox_buffer.sv
mbox_top.sv
tb_mbox.sv

//--- mbox_buffer.sv
// mailbox data buffer with synchronous read port, dataout register
// and the hold for a dataout read that arrives before the load
`timescale 1ns/1ns
`include "mbox_config.svh"

module mbox_buffer (
    input  logic                      clk,
    input  logic                      rst_b,
    input  logic                      write,
    input  logic [`MBOX_PTR_W-1:0]    wr_ptr,
    input  logic [`MBOX_DATA_W-1:0]   wdata,
    input  logic [`MBOX_PTR_W-1:0]    rd_ptr,
    input  logic                      rd_issue,
    input  logic                      rst_rd,
    input  logic                      rd_valid,
    input  logic                      dataout_rd,
    output logic [`MBOX_DATA_W-1:0]   dataout,
    output logic                      req_hold
);

    logic [`MBOX_DATA_W-1:0] mem [0:`MBOX_DEPTH-1];
    logic [`MBOX_DATA_W-1:0] rd_data;
    logic                    rd_pend;
    logic                    rd_valid_q;

    // a pointer reset preloads entry 0 for the first dataout read
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= wdata;
        end
        if (rd_issue | rst_rd) begin
            rd_data <= mem[rst_rd ? '0 : rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_pend    <= 1'b0;
            rd_valid_q <= 1'b0;
            dataout    <= '0;
        end else begin
            rd_pend <= rd_issue | rst_rd;
            if (rd_issue | rst_rd) begin
                rd_valid_q <= rd_valid;
            end
            // entries beyond the latched length read back as zero
            if (rd_pend) begin
                dataout <= rd_valid_q ? rd_data : '0;
            end
        end
    end

    assign req_hold = dataout_rd & rd_pend;

endmodule

//--- mbox_config.svh
// mailbox sizing macros
// data word, buffer depth, pointer, length, user and register address widths
`ifndef MBOX_CONFIG_SVH
`define MBOX_CONFIG_SVH

// width of one mailbox data word
`define MBOX_DATA_W 32
// number of words in the data buffer
`define MBOX_DEPTH 32
// buffer index width
`define MBOX_PTR_W 5
// length counted in words, one bit wider than a pointer so a full buffer fits
`define MBOX_DLEN_W 6
// width of the requester user id
`define MBOX_USER_W 8
// width of a register word index
`define MBOX_ADDR_W 4

`endif

//--- mbox_fsm.sv
// mailbox protocol FSM with lock ownership, requester and receiver checks,
// protocol error pulses, pointer commands and interrupts
`timescale 1ns/1ns

module mbox_fsm (
    input  logic                              clk,
    input  logic                              rst_b,
    input  logic                              req_dv,
    input  logic                              req_hold,
    input  mbox_pkg::mbox_req_t               req,
    input  mbox_pkg::mbox_reg_evt_t           evt,
    input  mbox_pkg::mbox_reg_state_t         regs,
    input  logic                              wr_full,
    output mbox_pkg::mbox_reg_ctrl_t          ctrl,
    output mbox_pkg::mbox_ptr_cmd_t           ptr_cmd,
    output logic                              uc_mbox_data_avail,
    output logic                              soc_mbox_data_avail,
    output logic                              soc_req_mbox_lock,
    output logic                              mbox_inv_pauser_axs,
    output mbox_pkg::mbox_protocol_error_t    mbox_protocol_error
);

    mbox_pkg::mbox_fsm_state_e      ps;
    mbox_pkg::mbox_fsm_state_e      ns;
    mbox_pkg::mbox_protocol_error_t err_nxt;
    logic                           soc_has_lock;
    logic                           req_ok;
    logic                           vreq;
    logic                           vrecv;
    logic                           soc_vld;
    logic                           wrong_order;
    logic                           exec_set;
    logic                           exec_clr;
    logic                           status_done;

    // a held request has no effect and comes back later
    assign req_ok = req_dv & ~req_hold;

    // the uC is the requester when it holds the lock or while it executes,
    // the soc only when it holds the lock under the same user id
    assign vreq = regs.lock &
                  ((~req.soc_req & (~soc_has_lock | (ps == mbox_pkg::MBOX_EXECUTE_UC))) |
                   (req.soc_req & soc_has_lock & (req.user == regs.user)));

    // the receiver is the other side in its execute state, or the requester
    // reading back a response in its own execute state
    assign vrecv = regs.lock &
                   ((~req.soc_req & soc_has_lock & (ps == mbox_pkg::MBOX_EXECUTE_UC)) |
                    (req.soc_req & ~soc_has_lock & (ps == mbox_pkg::MBOX_EXECUTE_SOC) &
                     (req.user == regs.user)) |
                    (vreq & ((soc_has_lock & (ps == mbox_pkg::MBOX_EXECUTE_SOC)) |
                             (~soc_has_lock & (ps == mbox_pkg::MBOX_EXECUTE_UC)))));

    assign ctrl.valid_requester = vreq;
    assign ctrl.valid_receiver  = vrecv;

    assign soc_vld     = req_ok & req.soc_req & vreq;
    assign exec_set    = evt.execute_wr & req.wdata[0];
    assign exec_clr    = evt.execute_wr & ~req.wdata[0];
    assign status_done = evt.status_wr & (req.wdata[3:0] != mbox_pkg::CMD_BUSY);

    always_comb begin
        ns          = ps;
        err_nxt     = '0;
        wrong_order = 1'b0;
        case (ps)
            mbox_pkg::MBOX_IDLE: begin
                if (evt.lock_rd) begin
                    ns = mbox_pkg::MBOX_RDY_FOR_CMD;
                end
                // flagged only, the mailbox stays idle
                err_nxt.axs_without_lock = req_ok & req.soc_req &
                                           (req.write | evt.dataout_rd);
            end
            mbox_pkg::MBOX_RDY_FOR_CMD: begin
                if (evt.cmd_wr) begin
                    ns = mbox_pkg::MBOX_RDY_FOR_DLEN;
                end else begin
                    wrong_order = soc_vld & (req.write ? (req.addr != mbox_pkg::REG_CMD) :
                                                         evt.dataout_rd);
                end
            end
            mbox_pkg::MBOX_RDY_FOR_DLEN: begin
                if (evt.dlen_wr) begin
                    ns = mbox_pkg::MBOX_RDY_FOR_DATA;
                end else begin
                    wrong_order = soc_vld & (req.write ? (req.addr != mbox_pkg::REG_DLEN) :
                                                         evt.dataout_rd);
                end
            end
            mbox_pkg::MBOX_RDY_FOR_DATA: begin
                // execute goes to the side that did not take the lock
                if (exec_set) begin
                    ns = soc_has_lock ? mbox_pkg::MBOX_EXECUTE_UC : mbox_pkg::MBOX_EXECUTE_SOC;
                end else begin
                    wrong_order = soc_vld &
                                  (req.write ? ~((req.addr == mbox_pkg::REG_DATAIN) |
                                                 (req.addr == mbox_pkg::REG_EXECUTE)) :
                                               evt.dataout_rd);
                end
            end
            mbox_pkg::MBOX_EXECUTE_UC: begin
                // no soc write is legal while the uC works on the command
                wrong_order = soc_vld & (req.write | evt.dataout_rd);
                if (!wrong_order && exec_clr) begin
                    ns = mbox_pkg::MBOX_IDLE;
                end else if (!wrong_order && soc_has_lock && status_done) begin
                    ns = mbox_pkg::MBOX_EXECUTE_SOC;
                end
            end
            mbox_pkg::MBOX_EXECUTE_SOC: begin
                if (exec_clr) begin
                    ns = mbox_pkg::MBOX_IDLE;
                end else if (!soc_has_lock && status_done) begin
                    ns = mbox_pkg::MBOX_EXECUTE_UC;
                end else begin
                    // soc reads are always fine here, it is consuming dataout
                    wrong_order = req_ok & req.soc_req & req.write &
                                  ((vreq & (req.addr != mbox_pkg::REG_EXECUTE)) |
                                   (~soc_has_lock & (req.addr != mbox_pkg::REG_STATUS) &
                                    (req.addr != mbox_pkg::REG_DLEN)));
                end
            end
            default: begin
                ns = ps;
            end
        endcase
        if (wrong_order) begin
            ns = mbox_pkg::MBOX_ERROR;
            err_nxt.axs_incorrect_order = 1'b1;
        end
        // force unlock leaves any state, the error state included
        if (evt.unlock_wr) begin
            ns      = mbox_pkg::MBOX_IDLE;
            err_nxt = '0;
        end
    end

    // lock and status clear on every way back to idle
    assign ctrl.lock_set    = (ps == mbox_pkg::MBOX_IDLE) & evt.lock_rd;
    assign ctrl.clr_lock    = (ns == mbox_pkg::MBOX_IDLE) & (ps != mbox_pkg::MBOX_IDLE);
    assign ctrl.clr_status  = ctrl.clr_lock;
    assign ctrl.clr_execute = evt.unlock_wr;

    // the length is frozen on any arc into an execute state
    assign ptr_cmd.latch_dlen = (ns != ps) & ((ns == mbox_pkg::MBOX_EXECUTE_UC) |
                                              (ns == mbox_pkg::MBOX_EXECUTE_SOC));
    assign ptr_cmd.rst_ptrs   = ptr_cmd.latch_dlen | ctrl.clr_lock;
    assign ptr_cmd.inc_wr     = evt.datain_wr & ~wr_full &
                                (ps inside {mbox_pkg::MBOX_RDY_FOR_DATA,
                                            mbox_pkg::MBOX_EXECUTE_UC,
                                            mbox_pkg::MBOX_EXECUTE_SOC});
    assign ptr_cmd.inc_rd     = req_ok & evt.dataout_rd & vrecv;

    assign uc_mbox_data_avail  = (ps == mbox_pkg::MBOX_EXECUTE_UC);
    assign soc_mbox_data_avail = (ps == mbox_pkg::MBOX_EXECUTE_SOC);

    // tells the uC that the soc wants the lock the uC is holding
    assign soc_req_mbox_lock = req_ok & ~req.write & req.soc_req &
                               (req.addr == mbox_pkg::REG_LOCK) & regs.lock & ~soc_has_lock;

    assign mbox_inv_pauser_axs = req_ok & req.soc_req & ~vreq & ~vrecv &
                                 (req.write | evt.dataout_rd);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            ps                  <= mbox_pkg::MBOX_IDLE;
            soc_has_lock        <= 1'b0;
            mbox_protocol_error <= '0;
        end else begin
            ps                  <= ns;
            // remember who took the lock until it is released
            soc_has_lock        <= ctrl.lock_set ? req.soc_req :
                                   regs.lock ? soc_has_lock : 1'b0;
            mbox_protocol_error <= err_nxt;
        end
    end

endmodule

//--- mbox_pkg.sv
// mailbox types: protocol states, register opcodes, command status values
// and the structs exchanged between the mailbox blocks
`include "mbox_config.svh"

package mbox_pkg;

    // protocol states of the mailbox FSM
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5,
        MBOX_ERROR        = 3'd6
    } mbox_fsm_state_e;

    // register word indexes seen on the request address
    typedef enum logic [`MBOX_ADDR_W-1:0] {
        REG_LOCK    = 4'd0,
        REG_USER    = 4'd1,
        REG_CMD     = 4'd2,
        REG_DLEN    = 4'd3,
        REG_DATAIN  = 4'd4,
        REG_DATAOUT = 4'd5,
        REG_EXECUTE = 4'd6,
        REG_STATUS  = 4'd7,
        REG_UNLOCK  = 4'd8
    } mbox_reg_e;

    // status written by the receiver, anything but busy hands the mailbox back
    typedef enum logic [3:0] {
        CMD_BUSY     = 4'd0,
        DATA_READY   = 4'd1,
        CMD_COMPLETE = 4'd2,
        CMD_FAILURE  = 4'd3
    } mbox_cmd_status_e;

    typedef struct packed {
        logic                    soc_req;
        logic                    write;
        logic [`MBOX_USER_W-1:0] user;
        mbox_reg_e               addr;
        logic [`MBOX_DATA_W-1:0] wdata;
    } mbox_req_t;

    // single cycle pulses decoded from the request
    typedef struct packed {
        logic lock_rd;
        logic cmd_wr;
        logic dlen_wr;
        logic datain_wr;
        logic dataout_rd;
        logic execute_wr;
        logic status_wr;
        logic unlock_wr;
    } mbox_reg_evt_t;

    typedef struct packed {
        logic                    lock;
        logic                    execute;
        mbox_cmd_status_e        status;
        logic [`MBOX_USER_W-1:0] user;
    } mbox_reg_state_t;

    typedef struct packed {
        logic inc_wr;
        logic inc_rd;
        logic rst_ptrs;
        logic latch_dlen;
    } mbox_ptr_cmd_t;

    typedef struct packed {
        logic lock_set;
        logic clr_lock;
        logic clr_status;
        logic clr_execute;
        logic valid_requester;
        logic valid_receiver;
    } mbox_reg_ctrl_t;

    typedef struct packed {
        logic axs_without_lock;
        logic axs_incorrect_order;
    } mbox_protocol_error_t;

endpackage

//--- mbox_ptr_ctrl.sv
// mailbox counters with write and read pointers, full flags,
// latched length in words and the read valid flag
`timescale 1ns/1ns
`include "mbox_config.svh"

module mbox_ptr_ctrl (
    input  logic                      clk,
    input  logic                      rst_b,
    input  mbox_pkg::mbox_ptr_cmd_t   ptr_cmd,
    input  logic [31:0]               dlen,
    output logic [`MBOX_PTR_W-1:0]    wr_ptr,
    output logic [`MBOX_PTR_W-1:0]    rd_ptr,
    output logic                      wr_full,
    output logic                      rd_valid
);

    logic [`MBOX_DLEN_W-1:0] dlen_words;
    logic [`MBOX_DLEN_W-1:0] dlen_nxt;
    logic [`MBOX_DLEN_W-1:0] dlen_q;
    logic                    rd_full;

    // byte length rounded up to words and capped at the buffer size
    always_comb begin
        if (dlen >= 32'(`MBOX_DEPTH * 4)) begin
            dlen_words = `MBOX_DLEN_W'(`MBOX_DEPTH);
        end else begin
            dlen_words = `MBOX_DLEN_W'(dlen[31:2]) + `MBOX_DLEN_W'(|dlen[1:0]);
        end
    end

    // a sender that wrote fewer words than it announced gets clamped,
    // a full buffer keeps the programmed length
    assign dlen_nxt = (~wr_full & ({1'b0, wr_ptr} < dlen_words)) ? {1'b0, wr_ptr} : dlen_words;

    // the preload of entry 0 happens with the reset, before dlen_q updates
    assign rd_valid = ptr_cmd.rst_ptrs ? (dlen_nxt != '0) :
                                         (~rd_full & ({1'b0, rd_ptr} < dlen_q));

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            wr_full <= 1'b0;
            rd_full <= 1'b0;
            dlen_q  <= '0;
        end else begin
            if (ptr_cmd.latch_dlen) begin
                dlen_q <= dlen_nxt;
            end
            // the read pointer restarts at 1 because entry 0 is preloaded
            if (ptr_cmd.rst_ptrs) begin
                wr_ptr  <= '0;
                rd_ptr  <= `MBOX_PTR_W'(1);
                wr_full <= 1'b0;
                rd_full <= 1'b0;
            end else begin
                // both pointers stop at the last entry and raise their full flag there
                if (ptr_cmd.inc_wr) begin
                    if (wr_ptr == `MBOX_PTR_W'(`MBOX_DEPTH - 1)) begin
                        wr_full <= 1'b1;
                    end else begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
                if (ptr_cmd.inc_rd) begin
                    if (rd_ptr == `MBOX_PTR_W'(`MBOX_DEPTH - 1)) begin
                        rd_full <= 1'b1;
                    end else if ({1'b0, rd_ptr} < dlen_q) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- mbox_regs.sv
// mailbox register block with request decode, architectural registers,
// event pulses for the FSM and the read data mux
`timescale 1ns/1ns
`include "mbox_config.svh"

module mbox_regs (
    input  logic                        clk,
    input  logic                        rst_b,
    input  logic                        req_dv,
    input  mbox_pkg::mbox_req_t         req,
    input  mbox_pkg::mbox_reg_ctrl_t    ctrl,
    input  logic [`MBOX_DATA_W-1:0]     dataout,
    output mbox_pkg::mbox_reg_evt_t     evt,
    output mbox_pkg::mbox_reg_state_t   regs,
    output logic [31:0]                 dlen,
    output logic [`MBOX_DATA_W-1:0]     rdata
);

    logic                    wr;
    logic                    rd;
    logic [`MBOX_DATA_W-1:0] cmd;

    // writes only land when they come from the agent that owns the transfer
    assign wr = req_dv & req.write & ctrl.valid_requester;
    assign rd = req_dv & ~req.write;

    // taking the lock is a plain read of the lock register while it is clear
    assign evt.lock_rd    = rd & (req.addr == mbox_pkg::REG_LOCK) & ~regs.lock;
    assign evt.cmd_wr     = wr & (req.addr == mbox_pkg::REG_CMD);
    assign evt.dlen_wr    = wr & (req.addr == mbox_pkg::REG_DLEN);
    assign evt.datain_wr  = wr & (req.addr == mbox_pkg::REG_DATAIN);
    // the FSM decides whether a dataout read is allowed to consume a word
    assign evt.dataout_rd = rd & (req.addr == mbox_pkg::REG_DATAOUT);
    assign evt.execute_wr = wr & (req.addr == mbox_pkg::REG_EXECUTE);
    assign evt.status_wr  = wr & (req.addr == mbox_pkg::REG_STATUS);
    // only a write of bit 0 forces the unlock
    assign evt.unlock_wr  = wr & (req.addr == mbox_pkg::REG_UNLOCK) & req.wdata[0];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            regs.lock    <= 1'b0;
            regs.user    <= '0;
            regs.execute <= 1'b0;
            regs.status  <= mbox_pkg::CMD_BUSY;
            cmd          <= '0;
            dlen         <= '0;
        end else begin
            // the user id is captured from the request that takes the lock
            if (ctrl.lock_set) begin
                regs.lock <= 1'b1;
                regs.user <= req.user;
            end else if (ctrl.clr_lock) begin
                regs.lock <= 1'b0;
            end
            if (evt.cmd_wr) begin
                cmd <= req.wdata;
            end
            if (evt.dlen_wr) begin
                dlen <= req.wdata;
            end
            // a hardware clear wins over a write in the same cycle
            if (ctrl.clr_execute) begin
                regs.execute <= 1'b0;
            end else if (evt.execute_wr) begin
                regs.execute <= req.wdata[0];
            end
            if (ctrl.clr_status) begin
                regs.status <= mbox_pkg::CMD_BUSY;
            end else if (evt.status_wr) begin
                regs.status <= mbox_pkg::mbox_cmd_status_e'(req.wdata[3:0]);
            end
        end
    end

    // the read data follows the address in the same cycle
    always_comb begin
        rdata = '0;
        case (req.addr)
            mbox_pkg::REG_LOCK:    rdata = `MBOX_DATA_W'(regs.lock);
            mbox_pkg::REG_USER:    rdata = `MBOX_DATA_W'(regs.user);
            mbox_pkg::REG_CMD:     rdata = cmd;
            mbox_pkg::REG_DLEN:    rdata = dlen;
            // agents that are not the receiver only ever see zero in dataout
            mbox_pkg::REG_DATAOUT: rdata = ctrl.valid_receiver ? dataout : '0;
            mbox_pkg::REG_EXECUTE: rdata = `MBOX_DATA_W'(regs.execute);
            mbox_pkg::REG_STATUS:  rdata = `MBOX_DATA_W'(regs.status);
            default:               rdata = '0;
        endcase
    end

endmodule

//--- mbox_top.sv
// mailbox top level wiring the register block, FSM, counters and buffer
`timescale 1ns/1ns
`include "mbox_config.svh"

module mbox_top (
    input  logic                              clk,
    input  logic                              rst_b,
    input  logic                              req_dv,
    input  mbox_pkg::mbox_req_t               req,
    output logic                              req_hold,
    output logic [`MBOX_DATA_W-1:0]           rdata,
    output logic                              uc_mbox_data_avail,
    output logic                              soc_mbox_data_avail,
    output logic                              soc_req_mbox_lock,
    output logic                              mbox_inv_pauser_axs,
    output mbox_pkg::mbox_protocol_error_t    mbox_protocol_error
);

    mbox_pkg::mbox_reg_evt_t   evt;
    mbox_pkg::mbox_reg_state_t regs;
    mbox_pkg::mbox_reg_ctrl_t  ctrl;
    mbox_pkg::mbox_ptr_cmd_t   ptr_cmd;
    logic [31:0]               dlen;
    logic [`MBOX_DATA_W-1:0]   dataout;
    logic [`MBOX_PTR_W-1:0]    wr_ptr;
    logic [`MBOX_PTR_W-1:0]    rd_ptr;
    logic                      wr_full;
    logic                      rd_valid;

    mbox_regs mbox_regs_i (
        .clk(clk), .rst_b(rst_b), .req_dv(req_dv), .req(req), .ctrl(ctrl),
        .dataout(dataout), .evt(evt), .regs(regs), .dlen(dlen), .rdata(rdata)
    );

    mbox_fsm mbox_fsm_i (
        .clk(clk), .rst_b(rst_b), .req_dv(req_dv), .req_hold(req_hold), .req(req),
        .evt(evt), .regs(regs), .wr_full(wr_full), .ctrl(ctrl), .ptr_cmd(ptr_cmd),
        .uc_mbox_data_avail(uc_mbox_data_avail), .soc_mbox_data_avail(soc_mbox_data_avail),
        .soc_req_mbox_lock(soc_req_mbox_lock), .mbox_inv_pauser_axs(mbox_inv_pauser_axs),
        .mbox_protocol_error(mbox_protocol_error)
    );

    mbox_ptr_ctrl mbox_ptr_ctrl_i (
        .clk(clk), .rst_b(rst_b), .ptr_cmd(ptr_cmd), .dlen(dlen), .wr_ptr(wr_ptr),
        .rd_ptr(rd_ptr), .wr_full(wr_full), .rd_valid(rd_valid)
    );

    // writes come from the request data, reads follow the pointer commands
    mbox_buffer mbox_buffer_i (
        .clk(clk), .rst_b(rst_b), .write(ptr_cmd.inc_wr), .wr_ptr(wr_ptr),
        .wdata(req.wdata), .rd_ptr(rd_ptr), .rd_issue(ptr_cmd.inc_rd),
        .rst_rd(ptr_cmd.rst_ptrs), .rd_valid(rd_valid), .dataout_rd(evt.dataout_rd),
        .dataout(dataout), .req_hold(req_hold)
    );

endmodule

//--- tb_mbox.sv
// mailbox testbench with clock, reset, stimulus table, data reference queue,
// a check task and a cycle limit
`timescale 1ns/1ns
`include "mbox_config.svh"

module tb_mbox;

    localparam logic [7:0] SOC_USER   = 8'h11;
    localparam logic [7:0] OTHER_USER = 8'h22;
    // extra flags of a row: {held once, soc_req_mbox_lock, invalid user, no lock, wrong order}
    // a held row is presented right after the previous row, without the idle cycle
    localparam logic [4:0] F_NONE    = 5'b00000;
    localparam logic [4:0] F_HOLD    = 5'b10000;
    localparam logic [4:0] F_IRQ     = 5'b01000;
    localparam logic [4:0] F_INV     = 5'b00100;
    localparam logic [4:0] F_NO_LOCK = 5'b00010;
    localparam logic [4:0] F_ORDER   = 5'b00001;

    typedef struct packed {
        logic hold;
        logic uc_avail;
        logic soc_avail;
        logic lock_irq;
        logic inv_axs;
        logic err_no_lock;
        logic err_order;
    } flags_t;

    typedef struct packed {
        mbox_pkg::mbox_req_t req;
        logic                chk_rdata;
        logic [31:0]         exp_rdata;
        flags_t              exp;
    } row_t;

    logic                           clk;
    logic                           rst_b;
    logic                           req_dv;
    mbox_pkg::mbox_req_t            req;
    logic                           req_hold;
    logic [`MBOX_DATA_W-1:0]        rdata;
    logic                           uc_mbox_data_avail;
    logic                           soc_mbox_data_avail;
    logic                           soc_req_mbox_lock;
    logic                           mbox_inv_pauser_axs;
    mbox_pkg::mbox_protocol_error_t mbox_protocol_error;

    row_t        rows[$];
    // words the receiver is expected to see, in order, already clamped to the length
    logic [31:0] ref_words[$];
    logic        uc_avail_m;
    logic        soc_avail_m;
    int          row_idx;
    int          cycles;
    int          cycle_limit;
    int unsigned seed_draw;

    mbox_top mbox_top_i (
        .clk(clk), .rst_b(rst_b), .req_dv(req_dv), .req(req), .req_hold(req_hold),
        .rdata(rdata), .uc_mbox_data_avail(uc_mbox_data_avail),
        .soc_mbox_data_avail(soc_mbox_data_avail), .soc_req_mbox_lock(soc_req_mbox_lock),
        .mbox_inv_pauser_axs(mbox_inv_pauser_axs), .mbox_protocol_error(mbox_protocol_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: row %0d %s is %h, expected %h",
                     $time, row_idx, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // data available levels come from the model state at the time the row is added
    task add_row(input logic soc, input logic [7:0] user, input logic write,
                 input mbox_pkg::mbox_reg_e addr, input logic [31:0] wdata,
                 input logic chk, input logic [31:0] exp_rdata, input logic [4:0] extra);
        row_t r;
        r.req.soc_req       = soc;
        r.req.write         = write;
        r.req.user          = user;
        r.req.addr          = addr;
        r.req.wdata         = wdata;
        r.chk_rdata         = chk;
        r.exp_rdata         = exp_rdata;
        r.exp.hold          = extra[4];
        r.exp.uc_avail      = uc_avail_m;
        r.exp.soc_avail     = soc_avail_m;
        r.exp.lock_irq      = extra[3];
        r.exp.inv_axs       = extra[2];
        r.exp.err_no_lock   = extra[1];
        r.exp.err_order     = extra[0];
        rows.push_back(r);
    endtask

    task add_write(input logic soc, input logic [7:0] user, input mbox_pkg::mbox_reg_e addr,
                   input logic [31:0] wdata, input logic [4:0] extra);
        add_row(soc, user, 1'b1, addr, wdata, 1'b0, 32'h0, extra);
    endtask

    task add_read(input logic soc, input logic [7:0] user, input mbox_pkg::mbox_reg_e addr,
                  input logic [31:0] exp_rdata, input logic [4:0] extra);
        add_row(soc, user, 1'b0, addr, 32'h0, 1'b1, exp_rdata, extra);
    endtask

    // the receiver gets the announced length in words, but never more than was written
    task send_message(input logic soc, input logic [7:0] user, input logic [31:0] dlen_bytes,
                      input int nwords);
        int          deliver;
        logic [31:0] w;
        add_write(soc, user, mbox_pkg::REG_CMD, 32'h0000_005a, F_NONE);
        add_write(soc, user, mbox_pkg::REG_DLEN, dlen_bytes, F_NONE);
        deliver = int'((dlen_bytes + 32'd3) / 32'd4);
        if (deliver > nwords) begin
            deliver = nwords;
        end
        for (int i = 0; i < nwords; i++) begin
            w = $urandom;
            if (i < deliver) begin
                ref_words.push_back(w);
            end
            add_write(soc, user, mbox_pkg::REG_DATAIN, w, F_NONE);
        end
        // execute hands the mailbox to the side that did not send
        if (soc) begin
            uc_avail_m = 1'b1;
        end else begin
            soc_avail_m = 1'b1;
        end
        add_write(soc, user, mbox_pkg::REG_EXECUTE, 32'h1, F_NONE);
    endtask

    // a first read in the cycle right after execute finds the preload pending and is held once
    task receive_words(input logic soc, input logic [7:0] user, input int nreads,
                       input logic right_after);
        logic [31:0] exp;
        logic [4:0]  extra;
        for (int i = 0; i < nreads; i++) begin
            if (ref_words.size() > 0) begin
                exp = ref_words.pop_front();
            end else begin
                exp = 32'h0;
            end
            extra = (i == 0 && right_after) ? F_HOLD : F_NONE;
            add_read(soc, user, mbox_pkg::REG_DATAOUT, exp, extra);
        end
    endtask

    task clear_execute(input logic soc, input logic [7:0] user);
        uc_avail_m  = 1'b0;
        soc_avail_m = 1'b0;
        add_write(soc, user, mbox_pkg::REG_EXECUTE, 32'h0, F_NONE);
    endtask

    task build_table();
        // lock taken by soc, then seen as set by both sides
        add_read(1'b1, SOC_USER, mbox_pkg::REG_LOCK, 32'h0, F_NONE);
        add_read(1'b1, SOC_USER, mbox_pkg::REG_LOCK, 32'h1, F_NONE);
        add_read(1'b0, SOC_USER, mbox_pkg::REG_LOCK, 32'h1, F_NONE);
        // soc to uc with 10 bytes in 3 words, and the lock is free again afterwards
        send_message(1'b1, SOC_USER, 32'd10, 3);
        receive_words(1'b0, SOC_USER, 4, 1'b1);
        clear_execute(1'b0, SOC_USER);
        add_read(1'b1, SOC_USER, mbox_pkg::REG_LOCK, 32'h0, F_NONE);
        // 16 bytes announced but only 2 words written
        send_message(1'b1, SOC_USER, 32'd16, 2);
        receive_words(1'b0, SOC_USER, 3, 1'b0);
        clear_execute(1'b0, SOC_USER);
        // datain before cmd is out of order, force unlock recovers
        add_read(1'b1, SOC_USER, mbox_pkg::REG_LOCK, 32'h0, F_NONE);
        add_write(1'b1, SOC_USER, mbox_pkg::REG_DATAIN, 32'hdead_beef, F_ORDER);
        add_write(1'b1, SOC_USER, mbox_pkg::REG_UNLOCK, 32'h1, F_NONE);
        add_read(1'b1, SOC_USER, mbox_pkg::REG_LOCK, 32'h0, F_NONE);
        add_write(1'b1, SOC_USER, mbox_pkg::REG_UNLOCK, 32'h1, F_NONE);
        // a soc write to an idle mailbox has no lock and no valid user
        add_write(1'b1, SOC_USER, mbox_pkg::REG_CMD, 32'h1, F_NO_LOCK | F_INV);
        // uc locks for the soc user, and a soc lock read then raises the interrupt
        add_read(1'b0, SOC_USER, mbox_pkg::REG_LOCK, 32'h0, F_NONE);
        add_read(1'b1, SOC_USER, mbox_pkg::REG_LOCK, 32'h1, F_IRQ);
        send_message(1'b0, SOC_USER, 32'd8, 2);
        add_read(1'b1, OTHER_USER, mbox_pkg::REG_DATAOUT, 32'h0, F_INV);
        receive_words(1'b1, SOC_USER, 3, 1'b0);
        clear_execute(1'b0, SOC_USER);
    endtask

    // request cycle with retry while held, then one idle cycle unless the next row is
    // presented at once
    task apply_row(input row_t r, input logic no_idle);
        logic held;
        logic first;
        held  = 1'b1;
        first = 1'b1;
        while (held) begin
            req_dv = 1'b1;
            req    = r.req;
            #5;
            held = req_hold;
            if (first) begin
                check_value(32'(req_hold), 32'(r.exp.hold), "req_hold");
            end
            first = 1'b0;
            if (!held) begin
                if (r.chk_rdata) begin
                    check_value(rdata, r.exp_rdata, "rdata");
                end
                check_value(32'(soc_req_mbox_lock), 32'(r.exp.lock_irq), "soc_req_mbox_lock");
                check_value(32'(mbox_inv_pauser_axs), 32'(r.exp.inv_axs), "mbox_inv_pauser_axs");
            end
            @(negedge clk);
        end
        // registered outputs of the served request stay put until the next rising edge
        check_value(32'(uc_mbox_data_avail), 32'(r.exp.uc_avail), "uc_mbox_data_avail");
        check_value(32'(soc_mbox_data_avail), 32'(r.exp.soc_avail), "soc_mbox_data_avail");
        check_value(32'(mbox_protocol_error.axs_without_lock), 32'(r.exp.err_no_lock),
                    "axs_without_lock");
        check_value(32'(mbox_protocol_error.axs_incorrect_order), 32'(r.exp.err_order),
                    "axs_incorrect_order");
        if (!no_idle) begin
            req_dv = 1'b0;
            req    = '0;
            @(negedge clk);
        end
    endtask

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the stimulus table did not complete within %0d cycles", cycle_limit);
        $display("Regression failed");
        $fatal(1, "simulation stopped by the cycle limit");
    end

    initial begin
        seed_draw   = $urandom(32'h82c2);
        rst_b       = 1'b0;
        req_dv      = 1'b0;
        req         = '0;
        uc_avail_m  = 1'b0;
        soc_avail_m = 1'b0;
        row_idx     = 0;
        build_table();
        cycle_limit = rows.size() * 4 + 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;
        @(negedge clk);
        foreach (rows[i]) begin
            row_idx = i;
            apply_row(rows[i], (i + 1 < rows.size()) && rows[i + 1].exp.hold);
        end
        $display("Regression passed");
        $finish;
    end

endmodule
